/* common/rv_pkg.sv */
package rv_pkg;

    // word and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [3:0]            alu_op_t;
    typedef logic [2:0]            imm_kind_t;

    // major opcodes handled by the core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // funct3 values the decoder looks at
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu codes are {funct7 bit 30, funct3}
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;

    // immediate formats
    localparam imm_kind_t IMM_I = 3'd0;
    localparam imm_kind_t IMM_S = 3'd1;
    localparam imm_kind_t IMM_B = 3'd2;
    localparam imm_kind_t IMM_U = 3'd3;
    localparam imm_kind_t IMM_J = 3'd4;

    // operand and next-pc selector codes
    localparam logic       ALU_A_REG  = 1'b0;
    localparam logic       ALU_A_PC   = 1'b1;
    localparam logic [1:0] ALU_B_REG  = 2'b00;
    localparam logic [1:0] ALU_B_IMM  = 2'b01;
    localparam logic [1:0] ALU_B_FOUR = 2'b10;
    localparam logic [1:0] ALU_B_RSVD = 2'b11;
    localparam logic       PC_A_FOUR  = 1'b0;
    localparam logic       PC_A_IMM   = 1'b1;
    localparam logic       PC_B_PC    = 1'b0;
    localparam logic       PC_B_RS1   = 1'b1;

    localparam xlen_t RESET_PC    = 32'h0000_0000;
    localparam xlen_t INSTR_BYTES = 32'd4;

    typedef struct packed {
        logic       reg_we;
        logic       alu_a_sel;
        logic [1:0] alu_b_sel;
        alu_op_t    alu_op;
        imm_kind_t  imm_kind;
        logic       pc_a_sel;
        logic       pc_b_sel;
    } ctrl_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        xlen_t     data;
    } retire_t;

endpackage

/* rtl/control_unit.sv */
`timescale 1ns/10ps

module control_unit (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      funct3,
    input  logic            funct7_b5,
    input  logic            less,
    input  logic            zero,
    output rv_pkg::ctrl_t   ctrl
);
    import rv_pkg::*;

    ctrl_t dec;
    logic  is_branch;
    logic  cond;

    assign is_branch = (opcode == OPC_BRANCH);

    // static decode, independent of the alu flags
    always_comb begin
        // unknown opcodes fall through as a no-op, pc + 4
        dec.reg_we    = 1'b0;
        dec.alu_a_sel = ALU_A_REG;
        dec.alu_b_sel = ALU_B_REG;
        dec.alu_op    = ALU_ADD;
        dec.imm_kind  = IMM_I;
        dec.pc_a_sel  = PC_A_FOUR;
        dec.pc_b_sel  = PC_B_PC;
        case (opcode)
            OPC_OP: begin
                dec.reg_we = 1'b1;
                // bit 30 only means something for add/sub and srl/sra
                dec.alu_op = {funct7_b5 && (funct3 == F3_ADD || funct3 == F3_SR), funct3};
            end
            OPC_OP_IMM: begin
                dec.reg_we    = 1'b1;
                dec.alu_b_sel = ALU_B_IMM;
                // addi has no sub form, bit 30 is immediate there
                dec.alu_op    = {funct7_b5 && (funct3 == F3_SR), funct3};
            end
            OPC_LUI: begin
                // rs1 index is forced to x0 in the core, so imm + 0
                dec.reg_we    = 1'b1;
                dec.alu_b_sel = ALU_B_IMM;
                dec.imm_kind  = IMM_U;
            end
            OPC_AUIPC: begin
                dec.reg_we    = 1'b1;
                dec.alu_a_sel = ALU_A_PC;
                dec.alu_b_sel = ALU_B_IMM;
                dec.imm_kind  = IMM_U;
            end
            OPC_JAL: begin
                // link value pc + 4 goes through the alu
                dec.reg_we    = 1'b1;
                dec.alu_a_sel = ALU_A_PC;
                dec.alu_b_sel = ALU_B_FOUR;
                dec.imm_kind  = IMM_J;
                dec.pc_a_sel  = PC_A_IMM;
            end
            OPC_JALR: begin
                dec.reg_we    = 1'b1;
                dec.alu_a_sel = ALU_A_PC;
                dec.alu_b_sel = ALU_B_FOUR;
                dec.pc_a_sel  = PC_A_IMM;
                dec.pc_b_sel  = PC_B_RS1;
            end
            OPC_BRANCH: begin
                dec.imm_kind = IMM_B;
                // compare rs1 against rs2
                case (funct3)
                    F3_BLT, F3_BGE:   dec.alu_op = ALU_SLT;
                    F3_BLTU, F3_BGEU: dec.alu_op = ALU_SLTU;
                    default:          dec.alu_op = ALU_SUB;
                endcase
            end
            default: ;
        endcase
    end

    // branch condition from the flags, negated forms inverted
    always_comb begin
        case (funct3)
            F3_BEQ:  cond = zero;
            F3_BNE:  cond = ~zero;
            F3_BLT:  cond = less;
            F3_BGE:  cond = ~less;
            F3_BLTU: cond = less;
            F3_BGEU: cond = ~less;
            default: cond = 1'b0;
        endcase
    end

    // taken branch swaps the +4 addend for the immediate
    always_comb begin
        ctrl = dec;
        if (is_branch && cond) begin
            ctrl.pc_a_sel = PC_A_IMM;
        end
    end

    always_comb begin
        b_sel_legal: assert (ctrl.alu_b_sel != ALU_B_RSVD)
            else $error("control_unit: reserved alu_b_sel for opcode %b", opcode);
    end

endmodule

/* rtl/imm_decoder.sv */
`timescale 1ns/10ps

module imm_decoder (
    input  rv_pkg::xlen_t     instr,
    input  rv_pkg::imm_kind_t imm_kind,
    output rv_pkg::xlen_t     imm
);
    import rv_pkg::*;

    // all formats sign extend from instr[31]
    always_comb begin
        case (imm_kind)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset, bit 0 always zero
            IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            // upper 20 bits, low 12 cleared
            IMM_U: imm = {instr[31:12], 12'b0};
            // jump offset, 21 bits scattered
            IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic              clk,
    input  rv_pkg::reg_addr_t raddr_a,
    input  rv_pkg::reg_addr_t raddr_b,
    output rv_pkg::xlen_t     rdata_a,
    output rv_pkg::xlen_t     rdata_b,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::xlen_t     wdata,
    input  logic              wen
);
    import rv_pkg::*;

    // x1..x31 only, x0 has no storage
    xlen_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    x0_zero_a: assert property (@(posedge clk) (raddr_a == '0) |-> (rdata_a == '0))
        else $error("register_file: x0 read nonzero on port a");
    x0_zero_b: assert property (@(posedge clk) (raddr_b == '0) |-> (rdata_b == '0))
        else $error("register_file: x0 read nonzero on port b");

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t   result,
    output logic            less,
    output logic            zero
);
    import rv_pkg::*;

    logic               subtract;
    xlen_t              b_eff;
    logic [XLEN:0]      sum;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [SHAMT_W-1:0] shamt;

    // one adder, compares reuse the subtraction
    assign subtract = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
    assign b_eff    = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, subtract};

    // no carry out of a - b means a < b unsigned
    assign lt_unsigned = ~sum[XLEN];
    // signs differ -> a negative wins, else sign of difference
    assign lt_signed   = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : sum[XLEN-1];

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB:  result = sum[XLEN-1:0];
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // flags for branch resolution
    assign less = (op == ALU_SLTU) ? lt_unsigned : lt_signed;
    assign zero = (result == '0);

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::xlen_t   instr,
    output rv_pkg::xlen_t   pc,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    ctrl_t     ctrl;
    xlen_t     imm;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     alu_a;
    xlen_t     alu_b;
    xlen_t     alu_y;
    xlen_t     pc_a;
    xlen_t     pc_b;
    xlen_t     pc_sum;
    xlen_t     pc_next;
    logic      less;
    logic      zero;
    logic      reg_we;

    // lui reads x0 so the alu computes imm + 0
    assign rs1 = (instr[6:0] == OPC_LUI) ? '0 : instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    control_unit u_control (
        .opcode    (instr[6:0]),
        .funct3    (instr[14:12]),
        .funct7_b5 (instr[30]),
        .less      (less),
        .zero      (zero),
        .ctrl      (ctrl)
    );

    imm_decoder u_imm (
        .instr    (instr),
        .imm_kind (ctrl.imm_kind),
        .imm      (imm)
    );

    // no write while held in reset
    assign reg_we = ctrl.reg_we & ~rst;

    register_file u_regs (
        .clk     (clk),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (src1),
        .rdata_b (src2),
        .waddr   (rd),
        .wdata   (alu_y),
        .wen     (reg_we)
    );

    // alu operands
    assign alu_a = (ctrl.alu_a_sel == ALU_A_PC) ? pc : src1;
    always_comb begin
        case (ctrl.alu_b_sel)
            ALU_B_IMM:  alu_b = imm;
            ALU_B_FOUR: alu_b = INSTR_BYTES;
            default:    alu_b = src2;
        endcase
    end

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_y),
        .less   (less),
        .zero   (zero)
    );

    // next pc = addend a + addend b
    assign pc_a   = (ctrl.pc_a_sel == PC_A_IMM) ? imm : INSTR_BYTES;
    assign pc_b   = (ctrl.pc_b_sel == PC_B_RS1) ? src1 : pc;
    assign pc_sum = pc_a + pc_b;
    // jalr target drops bit 0
    assign pc_next = (ctrl.pc_b_sel == PC_B_RS1) ? {pc_sum[XLEN-1:1], 1'b0} : pc_sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // write-back that commits at the coming edge
    assign retire.en   = reg_we;
    assign retire.rd   = rd;
    assign retire.data = alu_y;

    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("rv_core: pc %h not word aligned", pc);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);
    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held over the first edges, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
    end

endmodule

/* bench/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + 20;
    localparam int DRIVE_DELAY    = 1;
    localparam logic [31:0] SEED  = 32'h3d34_5fad;

    // instruction classes with their own checks
    localparam logic [2:0] K_NOP    = 3'd0;
    localparam logic [2:0] K_ALU    = 3'd1;
    localparam logic [2:0] K_UPPER  = 3'd2;
    localparam logic [2:0] K_BRANCH = 3'd3;
    localparam logic [2:0] K_JUMP   = 3'd4;

    logic       clk;
    logic       rst;
    xlen_t      instr;
    xlen_t      pc;
    retire_t    retire;

    // reference model state
    xlen_t      model_regs [0:NUM_REGS-1];
    xlen_t      model_pc;
    xlen_t      exp_next_pc;
    retire_t    exp_ret;
    logic [2:0] kind;
    logic [2:0] prev_kind;
    logic       uses_x0;
    logic       running;

    int err_reset  = 0;
    int err_alu    = 0;
    int err_upper  = 0;
    int err_branch = 0;
    int err_jump   = 0;
    int err_x0     = 0;
    int err_pc     = 0;
    int cycles     = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    rv_core dut (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    // instruction word builders in RV32I field order
    function automatic xlen_t rtype_word(logic alt, reg_addr_t rs2, reg_addr_t rs1,
                                         logic [2:0] f3, reg_addr_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic xlen_t itype_word(logic [11:0] imm12, reg_addr_t rs1,
                                         logic [2:0] f3, reg_addr_t rd, opcode_t op);
        return {imm12, rs1, f3, rd, op};
    endfunction

    function automatic xlen_t branch_word(xlen_t off, reg_addr_t rs2, reg_addr_t rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic xlen_t jump_word(xlen_t off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // integer ops by funct3 and instruction bit 30
    function automatic xlen_t arith_result(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // x0 about one time in eight
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(7) == 0) begin
            return '0;
        end
        return 5'($urandom_range(31, 1));
    endfunction

    // warm-up load of xN by addi from x0
    task automatic load_register(reg_addr_t rd);
        logic [11:0] imm12;
        imm12   = 12'($urandom);
        instr   = itype_word(imm12, '0, 3'd0, rd, OPC_OP_IMM);
        kind    = K_ALU;
        uses_x0 = 1'b1;
        exp_ret = {1'b1, rd, {{20{imm12[11]}}, imm12}};
        exp_next_pc = model_pc + 32'd4;
    endtask

    task automatic issue_random();
        int          sel;
        int          off;
        int          start;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        xlen_t       imm;
        xlen_t       raw;
        sel     = int'($urandom_range(99));
        rd      = pick_reg();
        rs1     = pick_reg();
        rs2     = pick_reg();
        f3      = 3'($urandom_range(7));
        alt     = 1'b0;
        uses_x0 = 1'b0;
        exp_ret = '0;
        exp_next_pc = model_pc + 32'd4;
        if (sel < 35) begin
            // bit 30 only on add/sub and srl/sra
            if (f3 == 3'd0 || f3 == 3'd5) begin
                alt = 1'($urandom_range(1));
            end
            instr   = rtype_word(alt, rs2, rs1, f3, rd);
            kind    = K_ALU;
            uses_x0 = (rs1 == '0) || (rs2 == '0);
            exp_ret = {1'b1, rd, arith_result(f3, alt, model_regs[rs1], model_regs[rs2])};
        end else if (sel < 60) begin
            imm12 = 12'($urandom);
            // shift forms carry shamt plus the sra bit
            if (f3 == 3'd1) begin
                imm12 = {7'b0, imm12[4:0]};
            end else if (f3 == 3'd5) begin
                alt   = imm12[10];
                imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
            end
            imm     = {{20{imm12[11]}}, imm12};
            instr   = itype_word(imm12, rs1, f3, rd, OPC_OP_IMM);
            kind    = K_ALU;
            uses_x0 = (rs1 == '0);
            exp_ret = {1'b1, rd, arith_result(f3, alt, model_regs[rs1], imm)};
        end else if (sel < 70) begin
            raw  = $urandom;
            imm  = {raw[31:12], 12'b0};
            kind = K_UPPER;
            if (raw[0]) begin
                instr   = {imm[31:12], rd, OPC_LUI};
                exp_ret = {1'b1, rd, imm};
            end else begin
                instr   = {imm[31:12], rd, OPC_AUIPC};
                exp_ret = {1'b1, rd, model_pc + imm};
            end
        end else if (sel < 88) begin
            // legal branch funct3 is 0, 1 or 4 to 7
            f3 = 3'($urandom_range(5));
            if (f3 >= 3'd2) begin
                f3 = f3 + 3'd2;
            end
            // equal operands now and then
            if ($urandom_range(3) == 0) begin
                rs2 = rs1;
            end
            off   = int'($urandom_range(16)) - 8;
            imm   = xlen_t'(off * 4);
            instr = branch_word(imm, rs2, rs1, f3);
            kind  = K_BRANCH;
            if (branch_taken(f3, model_regs[rs1], model_regs[rs2])) begin
                exp_next_pc = model_pc + imm;
            end
        end else if (sel < 98) begin
            kind    = K_JUMP;
            exp_ret = {1'b1, rd, model_pc + 32'd4};
            off     = int'($urandom_range(32)) - 16;
            if (sel < 93) begin
                imm   = xlen_t'(off * 4);
                instr = jump_word(imm, rd);
                exp_next_pc = model_pc + imm;
            end else begin
                // highest aligned base at or below start or x0
                start = int'($urandom_range(31));
                rs1   = '0;
                for (int i = start; i > 0; i--) begin
                    if (rs1 == '0 && model_regs[5'(i)][1:0] == 2'b00) begin
                        rs1 = 5'(i);
                    end
                end
                // odd offsets check that bit 0 is dropped
                imm   = xlen_t'(off * 4) + xlen_t'($urandom_range(1));
                instr = itype_word(imm[11:0], rs1, 3'd0, rd, OPC_JALR);
                exp_next_pc = (model_regs[rs1] + imm) & ~32'd1;
            end
        end else begin
            // unsupported opcode only steps the pc
            instr = '0;
            kind  = K_NOP;
        end
    endtask

    // apply the instruction that retired at the last edge
    task automatic commit_model();
        if (exp_ret.en && exp_ret.rd != '0) begin
            model_regs[exp_ret.rd] = exp_ret.data;
        end
        model_pc  = exp_next_pc;
        prev_kind = kind;
    endtask

    initial begin
        int total;
        void'($urandom(SEED));
        // a writing addi held through reset must not retire
        instr       = itype_word(12'h5a5, '0, 3'd0, 5'd1, OPC_OP_IMM);
        running     = 1'b0;
        kind        = K_NOP;
        prev_kind   = K_NOP;
        uses_x0     = 1'b0;
        exp_ret     = '0;
        model_pc    = RESET_PC;
        exp_next_pc = RESET_PC;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[5'(i)] = '0;
        end
        @(negedge rst);
        running = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            // every register gets a known value first
            if (n < NUM_REGS - 1) begin
                load_register(5'(n + 1));
            end else begin
                issue_random();
            end
            @(posedge clk);
            #DRIVE_DELAY;
            commit_model();
        end
        // one idle word so the last next pc is seen
        instr       = '0;
        kind        = K_NOP;
        exp_ret     = '0;
        uses_x0     = 1'b0;
        exp_next_pc = model_pc + 32'd4;
        @(posedge clk);
        #DRIVE_DELAY;
        running = 1'b0;
        total = err_reset + err_alu + err_upper + err_branch + err_jump + err_x0 + err_pc;
        $display("errors: reset %0d alu %0d upper %0d branch %0d jump %0d x0 %0d pc %0d",
                 err_reset, err_alu, err_upper, err_branch, err_jump, err_x0, err_pc);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // pc parked at the reset value until one cycle past reset
    reset_pc: assert property (@(posedge clk) rst |=> (pc == RESET_PC))
        else begin
            err_reset++;
            $display("** Error reset_pc: expected %h actual %h", RESET_PC, $sampled(pc));
        end
    reset_quiet: assert property (@(posedge clk) rst |-> !retire.en)
        else begin
            err_reset++;
            $display("** Error reset_retire: expected en 0 actual %b", $sampled(retire.en));
        end

    alu_result: assert property (@(posedge clk) (running && kind == K_ALU) |-> retire == exp_ret)
        else begin
            err_alu++;
            $display("** Error alu_result: expected %h actual %h", exp_ret, $sampled(retire));
        end
    upper_result: assert property (@(posedge clk)
        (running && kind == K_UPPER) |-> retire == exp_ret)
        else begin
            err_upper++;
            $display("** Error upper_imm: expected %h actual %h", exp_ret, $sampled(retire));
        end

    branch_quiet: assert property (@(posedge clk) (running && kind == K_BRANCH) |-> !retire.en)
        else begin
            err_branch++;
            $display("** Error branch_retire: expected en 0 actual %b", $sampled(retire.en));
        end
    branch_pc: assert property (@(posedge clk)
        (running && prev_kind == K_BRANCH) |-> pc == model_pc)
        else begin
            err_branch++;
            $display("** Error branch_target: expected %h actual %h", model_pc, $sampled(pc));
        end

    // link value then jump target
    jump_link: assert property (@(posedge clk) (running && kind == K_JUMP) |-> retire == exp_ret)
        else begin
            err_jump++;
            $display("** Error jump_link: expected %h actual %h", exp_ret, $sampled(retire));
        end
    jump_pc: assert property (@(posedge clk) (running && prev_kind == K_JUMP) |-> pc == model_pc)
        else begin
            err_jump++;
            $display("** Error jump_target: expected %h actual %h", model_pc, $sampled(pc));
        end

    // x0 as a source must still read zero
    x0_source: assert property (@(posedge clk)
        (running && kind == K_ALU && uses_x0) |-> retire.data == exp_ret.data)
        else begin
            err_x0++;
            $display("** Error x0_source: expected %h actual %h",
                     exp_ret.data, $sampled(retire.data));
        end

    step_pc: assert property (@(posedge clk)
        (running && prev_kind != K_BRANCH && prev_kind != K_JUMP) |-> pc == model_pc)
        else begin
            err_pc++;
            $display("** Error pc_step: expected %h actual %h", model_pc, $sampled(pc));
        end

endmodule

/* files.f */
common/rv_pkg.sv
rtl/control_unit.sv
rtl/imm_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/rv_core.sv
bench/tb_clock.sv
bench/rv_core_tb.sv

/* Makefile */
TOP := rv_core_tb

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# pass only when the run prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

lint:
	verilator --lint-only --timing -f files.f --top-module rv_core
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
